/* common/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data and address width
`define XLEN 64

// integer register count
`define NREGS 32

// first fetch address after reset
`define RESET_PC 64'h8000_0000

`endif

/* common/core_pkg.sv */
`include "core_settings.svh"

package core_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [31:0]      inst_t;
    typedef logic [4:0]       reg_addr_t;

    // one-hot alu operation
    // bits 11:7 are reserved
    typedef logic [11:0]      alu_op_t;

    localparam int ALU_ADD   = 0;
    localparam int ALU_XOR   = 1;
    localparam int ALU_OR    = 2;
    localparam int ALU_AND   = 3;
    localparam int ALU_SLT   = 4;
    localparam int ALU_SLTU  = 5;
    localparam int ALU_PASS2 = 6;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [1:0] {
        SRC1_RS1,
        SRC1_PC,
        SRC1_ZERO
    } src1_sel_t;

    typedef enum logic [1:0] {
        SRC2_RS2,
        SRC2_IMM_I,
        SRC2_IMM_U,
        SRC2_FOUR
    } src2_sel_t;

    typedef enum logic [1:0] {
        NPC_PC4,
        NPC_JAL,
        NPC_JALR
    } npc_sel_t;

endpackage

/* common/ctrl_if.sv */
interface ctrl_if;
    import core_pkg::*;

    alu_op_t   alu_op;
    logic      rf_we;
    src1_sel_t sel_src1;
    src2_sel_t sel_src2;
    npc_sel_t  sel_npc;

    modport ctrl (
        output alu_op, rf_we, sel_src1, sel_src2, sel_npc
    );

    // decode side consumers
    modport dec (
        input alu_op, rf_we, sel_src1, sel_src2
    );

    modport npc (
        input sel_npc
    );

endinterface

/* idu/control_unit.sv */
module control_unit (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    ctrl_if.ctrl       ctrl
);
    import core_pkg::*;

    always_comb begin
        // nop unless decoded below
        ctrl.alu_op          = '0;
        ctrl.alu_op[ALU_ADD] = 1'b1;
        ctrl.rf_we           = 1'b0;
        ctrl.sel_src1        = SRC1_ZERO;
        ctrl.sel_src2        = SRC2_RS2;
        ctrl.sel_npc         = NPC_PC4;

        case (opcode)
            OPC_OP_IMM: begin
                // shift-immediates stay nops
                if (funct3 != 3'b001 && funct3 != 3'b101) begin
                    ctrl.rf_we    = 1'b1;
                    ctrl.sel_src1 = SRC1_RS1;
                    ctrl.sel_src2 = SRC2_IMM_I;
                    ctrl.alu_op   = '0;
                    case (funct3)
                        3'b010:  ctrl.alu_op[ALU_SLT]  = 1'b1;
                        3'b011:  ctrl.alu_op[ALU_SLTU] = 1'b1;
                        3'b100:  ctrl.alu_op[ALU_XOR]  = 1'b1;
                        3'b110:  ctrl.alu_op[ALU_OR]   = 1'b1;
                        3'b111:  ctrl.alu_op[ALU_AND]  = 1'b1;
                        default: ctrl.alu_op[ALU_ADD]  = 1'b1;
                    endcase
                end
            end
            OPC_LUI: begin
                ctrl.rf_we             = 1'b1;
                ctrl.sel_src2          = SRC2_IMM_U;
                ctrl.alu_op            = '0;
                ctrl.alu_op[ALU_PASS2] = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.rf_we    = 1'b1;
                ctrl.sel_src1 = SRC1_PC;
                ctrl.sel_src2 = SRC2_IMM_U;
            end
            // link value is pc + 4 from the alu adder
            OPC_JAL: begin
                ctrl.rf_we    = 1'b1;
                ctrl.sel_src1 = SRC1_PC;
                ctrl.sel_src2 = SRC2_FOUR;
                ctrl.sel_npc  = NPC_JAL;
            end
            OPC_JALR: begin
                ctrl.rf_we    = 1'b1;
                ctrl.sel_src1 = SRC1_PC;
                ctrl.sel_src2 = SRC2_FOUR;
                ctrl.sel_npc  = NPC_JALR;
            end
            default: ;
        endcase
    end

endmodule

/* idu/regfile.sv */
`include "core_settings.svh"

module regfile (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::reg_addr_t raddr1,
    input  core_pkg::reg_addr_t raddr2,
    input  core_pkg::reg_addr_t waddr,
    input  logic                wen,
    input  core_pkg::xlen_t     wdata,
    output core_pkg::xlen_t     rdata1,
    output core_pkg::xlen_t     rdata2
);
    import core_pkg::*;

    xlen_t regs [`NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is never written, so it keeps its reset zero
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

/* idu/idu.sv */
`include "core_settings.svh"

module idu (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::xlen_t    pc,
    input  core_pkg::inst_t    inst,
    input  core_pkg::xlen_t    rf_wdata,
    ctrl_if                    ctrl,
    output core_pkg::alu_op_t  alu_op,
    output core_pkg::xlen_t    alu_src1,
    output core_pkg::xlen_t    alu_src2,
    output core_pkg::xlen_t    rdata1,
    output core_pkg::xlen_t    imm_i,
    output core_pkg::xlen_t    imm_j,
    output core_pkg::reg_addr_t wb_rd
);
    import core_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [20:0] imm_j_raw;
    xlen_t       imm_u;
    xlen_t       rf_rdata1;
    xlen_t       rf_rdata2;

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign rd        = inst[11:7];
    assign rs1       = inst[19:15];
    assign rs2       = inst[24:20];
    assign imm_j_raw = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // sign extension to full width
    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_j = {{(`XLEN-21){inst[31]}}, imm_j_raw};
    assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};

    control_unit u_control_unit (
        .opcode (opcode),
        .funct3 (funct3),
        .ctrl   (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .waddr  (rd),
        .wen    (ctrl.rf_we),
        .wdata  (rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    // operand select
    always_comb begin
        case (ctrl.sel_src1)
            SRC1_RS1: alu_src1 = rf_rdata1;
            SRC1_PC:  alu_src1 = pc;
            default:  alu_src1 = '0;
        endcase
    end

    always_comb begin
        case (ctrl.sel_src2)
            SRC2_RS2:   alu_src2 = rf_rdata2;
            SRC2_IMM_I: alu_src2 = imm_i;
            SRC2_IMM_U: alu_src2 = imm_u;
            default:    alu_src2 = xlen_t'(4);
        endcase
    end

    assign alu_op = ctrl.alu_op;
    assign rdata1 = rf_rdata1;
    assign wb_rd  = rd;

endmodule

/* rtl/exu.sv */
module exu (
    input  core_pkg::alu_op_t alu_op,
    input  core_pkg::xlen_t   src1,
    input  core_pkg::xlen_t   src2,
    output core_pkg::xlen_t   result
);
    import core_pkg::*;

    xlen_t sum;
    logic  lt_s;
    logic  lt_u;

    assign sum  = src1 + src2;
    assign lt_s = $signed(src1) < $signed(src2);
    assign lt_u = src1 < src2;

    // and-or mux over the one-hot op
    always_comb begin
        result = '0;
        if (alu_op[ALU_ADD])   result = result | sum;
        if (alu_op[ALU_XOR])   result = result | (src1 ^ src2);
        if (alu_op[ALU_OR])    result = result | (src1 | src2);
        if (alu_op[ALU_AND])   result = result | (src1 & src2);
        if (alu_op[ALU_SLT])   result = result | xlen_t'(lt_s);
        if (alu_op[ALU_SLTU])  result = result | xlen_t'(lt_u);
        if (alu_op[ALU_PASS2]) result = result | src2;
    end

endmodule

/* rtl/next_pc.sv */
module next_pc (
    input  core_pkg::xlen_t pc,
    input  core_pkg::xlen_t rdata1,
    input  core_pkg::xlen_t imm_i,
    input  core_pkg::xlen_t imm_j,
    ctrl_if.npc             ctrl,
    output core_pkg::xlen_t npc
);
    import core_pkg::*;

    xlen_t pc_add4;
    xlen_t jal_pc;
    xlen_t jalr_sum;
    xlen_t jalr_pc;

    assign pc_add4  = pc + xlen_t'(4);
    assign jal_pc   = pc + imm_j;
    assign jalr_sum = rdata1 + imm_i;
    // jalr target drops bit 0
    assign jalr_pc  = {jalr_sum[$bits(xlen_t)-1:1], 1'b0};

    always_comb begin
        case (ctrl.sel_npc)
            NPC_JAL:  npc = jal_pc;
            NPC_JALR: npc = jalr_pc;
            default:  npc = pc_add4;
        endcase
    end

endmodule

/* rtl/core_top.sv */
`include "core_settings.svh"

module core_top (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::inst_t     inst,
    output core_pkg::xlen_t     pc,
    output logic                wb_en,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::xlen_t     wb_data
);
    import core_pkg::*;

    alu_op_t alu_op;
    xlen_t   alu_src1;
    xlen_t   alu_src2;
    xlen_t   rdata1;
    xlen_t   imm_i;
    xlen_t   imm_j;
    xlen_t   result;
    xlen_t   npc;

    ctrl_if u_ctrl ();

    idu u_idu (
        .clk      (clk),
        .rst      (rst),
        .pc       (pc),
        .inst     (inst),
        .rf_wdata (result),
        .ctrl     (u_ctrl),
        .alu_op   (alu_op),
        .alu_src1 (alu_src1),
        .alu_src2 (alu_src2),
        .rdata1   (rdata1),
        .imm_i    (imm_i),
        .imm_j    (imm_j),
        .wb_rd    (wb_rd)
    );

    exu u_exu (
        .alu_op (alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (result)
    );

    next_pc u_next_pc (
        .pc     (pc),
        .rdata1 (rdata1),
        .imm_i  (imm_i),
        .imm_j  (imm_j),
        .ctrl   (u_ctrl.npc),
        .npc    (npc)
    );

    // one instruction retires per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else begin
            pc <= npc;
        end
    end

    assign wb_en   = u_ctrl.rf_we;
    assign wb_data = result;

endmodule

/* bench/core_assert.sv */
module core_assert (
    input logic                clk,
    input logic                rst,
    input core_pkg::xlen_t     pc,
    input logic                wb_en,
    input core_pkg::xlen_t     x0_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // pc is at least 2-byte aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0)
        else $error("pc bit zero is set, pc = %h", pc);

    a_x0_zero: assert property (@(posedge clk) disable iff (rst) x0_data == '0)
        else $error("register x0 holds a nonzero value %h", x0_data);

    a_no_wb_in_reset: assert property (@(posedge clk) rst |-> !wb_en)
        else $error("write-back enable is high during reset");

endmodule

bind core_top core_assert u_core_assert (
    .clk     (clk),
    .rst     (rst),
    .pc      (pc),
    .wb_en   (wb_en),
    .x0_data (u_idu.u_regfile.regs[0])
);

/* bench/core_tb.sv */
`include "core_settings.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    localparam int NUM_INSTS      = 2000;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = NUM_INSTS + RESET_CYCLES + 100;

    logic      clk;
    logic      rst;
    inst_t     inst;
    xlen_t     pc;
    logic      wb_en;
    reg_addr_t wb_rd;
    xlen_t     wb_data;

    // reference model state
    xlen_t     model_regs [32];
    xlen_t     model_pc;

    // prediction for the instruction in flight
    string     cur_name;
    logic      exp_en;
    reg_addr_t exp_rd;
    xlen_t     exp_data;
    xlen_t     exp_npc;

    core_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .inst    (inst),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("Some tests failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            report_failure("stopped at the first wrong value");
        end
    endtask

    function automatic xlen_t sext12(input logic [11:0] v);
        logic signed [63:0] s;
        s = $signed(v);
        return xlen_t'(s);
    endfunction

    function automatic xlen_t sext21(input logic [20:0] v);
        logic signed [63:0] s;
        s = $signed(v);
        return xlen_t'(s);
    endfunction

    function automatic xlen_t sext32(input logic [31:0] v);
        logic signed [63:0] s;
        s = $signed(v);
        return xlen_t'(s);
    endfunction

    // builds one random instruction, drives it and predicts its effect
    task automatic drive_random_inst(input int n);
        int unsigned kind;
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [20:0] jimm;
        xlen_t       src;
        xlen_t       imm;
        string       name;

        kind   = $urandom_range(0, 9);
        funct3 = 3'($urandom_range(0, 7));
        rd     = 5'($urandom_range(0, 31));
        rs1    = 5'($urandom_range(0, 31));
        imm12  = 12'($urandom);
        imm20  = 20'($urandom);
        jimm   = {imm20, 1'b0};
        src    = model_regs[rs1];
        imm    = sext12(imm12);

        exp_en   = 1'b1;
        exp_rd   = rd;
        exp_data = '0;
        exp_npc  = model_pc + 64'd4;

        case (kind)
            0, 1, 2, 3: begin
                opcode = 7'b0010011;
                inst   = {imm12, rs1, funct3, rd, opcode};
                case (funct3)
                    3'd0: begin
                        name     = "addi";
                        exp_data = src + imm;
                    end
                    3'd2: begin
                        name     = "slti";
                        exp_data = ($signed(src) < $signed(imm)) ? 64'd1 : 64'd0;
                    end
                    3'd3: begin
                        name     = "sltiu";
                        exp_data = (src < imm) ? 64'd1 : 64'd0;
                    end
                    3'd4: begin
                        name     = "xori";
                        exp_data = src ^ imm;
                    end
                    3'd6: begin
                        name     = "ori";
                        exp_data = src | imm;
                    end
                    3'd7: begin
                        name     = "andi";
                        exp_data = src & imm;
                    end
                    default: begin
                        // shift immediates act as nops
                        name   = "shift-imm nop";
                        exp_en = 1'b0;
                    end
                endcase
            end
            4: begin
                name     = "lui";
                inst     = {imm20, rd, 7'b0110111};
                exp_data = sext32({imm20, 12'b0});
            end
            5: begin
                name     = "auipc";
                inst     = {imm20, rd, 7'b0010111};
                exp_data = model_pc + sext32({imm20, 12'b0});
            end
            6: begin
                name     = "jal";
                inst     = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], rd, 7'b1101111};
                exp_data = model_pc + 64'd4;
                exp_npc  = model_pc + sext21(jimm);
            end
            7: begin
                name     = "jalr";
                inst     = {imm12, rs1, 3'b000, rd, 7'b1100111};
                exp_data = model_pc + 64'd4;
                exp_npc  = (src + imm) & ~64'd1;
            end
            default: begin
                case ($urandom_range(0, 5))
                    0:       opcode = 7'b0110011;
                    1:       opcode = 7'b0000011;
                    2:       opcode = 7'b0100011;
                    3:       opcode = 7'b1100011;
                    4:       opcode = 7'b0011011;
                    default: opcode = 7'b1110011;
                endcase
                name   = "unsupported";
                inst   = {imm12, rs1, funct3, rd, opcode};
                exp_en = 1'b0;
            end
        endcase
        cur_name = $sformatf("%s #%0d", name, n);
    endtask

    // watchdog
    initial begin
        for (int i = 0; i < TIMEOUT_CYCLES; i++) begin
            @(posedge clk);
        end
        report_failure($sformatf("timeout: run did not finish in %0d cycles", TIMEOUT_CYCLES));
    end

    initial begin
        void'($urandom(32'h62d5));
        rst  = 1'b1;
        inst = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc = `RESET_PC;

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst = 1'b0;
        check_value("reset pc", `RESET_PC, pc);
        check_value("reset wb_en", 64'd0, 64'(wb_en));

        for (int n = 0; n < NUM_INSTS; n++) begin
            check_value({"pc before ", $sformatf("#%0d", n)}, model_pc, pc);
            drive_random_inst(n);

            // outputs are still settled before the edge takes effect
            @(posedge clk);
            check_value({cur_name, " wb_en"}, 64'(exp_en), 64'(wb_en));
            if (exp_en) begin
                check_value({cur_name, " wb_rd"}, 64'(exp_rd), 64'(wb_rd));
                check_value({cur_name, " wb_data"}, exp_data, wb_data);
            end

            if (exp_en && exp_rd != 5'd0) begin
                model_regs[exp_rd] = exp_data;
            end
            model_pc = exp_npc;
            @(negedge clk);
        end

        check_value("final pc", model_pc, pc);
        $display("All tests passed");
        $finish;
    end

endmodule

/* all.f */
+incdir+common
common/core_pkg.sv
common/ctrl_if.sv
idu/control_unit.sv
idu/regfile.sv
idu/idu.sv
rtl/exu.sv
rtl/next_pc.sv
rtl/core_top.sv
bench/core_assert.sv
bench/core_tb.sv

/* Makefile */
SIM      := verilator
TOP      := core_tb
FILELIST := all.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
